/* hdl/eth_tx_pkg.sv */
//--------------------------------------------------------------------------
// ethernet transmit scheduler, shared definitions
// widths, channel numbering, frame constants and fsm encodings
//--------------------------------------------------------------------------

`default_nettype none

package eth_tx_pkg;

  //------------------------------------------------------------------------
  // channels
  //------------------------------------------------------------------------
  localparam int num_channels = 4;

  typedef logic [1:0]  chan_t;   // channel index, lower wins
  typedef logic [7:0]  byte_t;   // one wire byte
  typedef logic [10:0] len_t;    // payload bytes, 1..1500
  typedef logic [47:0] mac_t;
  typedef logic [31:0] crc_t;

  localparam chan_t ch_arp  = 2'd0;  // address resolution
  localparam chan_t ch_icmp = 2'd1;  // echo reply
  localparam chan_t ch_dhcp = 2'd2;  // address lease
  localparam chan_t ch_udp  = 2'd3;  // user datagram

  //------------------------------------------------------------------------
  // frame layout
  //------------------------------------------------------------------------
  localparam int    preamble_len  = 7;
  localparam byte_t preamble_byte = 8'h55;
  localparam byte_t sfd_byte      = 8'hd5;
  localparam int    mac_bytes     = 6;
  localparam int    type_bytes    = 2;
  localparam int    fcs_bytes     = 4;
  localparam int    ifg_len       = 12;   // idle cycles between frames

  localparam logic [15:0] ethertype_arp = 16'h0806;
  localparam logic [15:0] ethertype_ip  = 16'h0800;

  // reflected crc-32, inverted on the wire
  localparam crc_t crc_poly = 32'hedb88320;
  localparam crc_t crc_init = 32'hffffffff;

  //------------------------------------------------------------------------
  // state machines
  //------------------------------------------------------------------------
  typedef enum logic [1:0] {
    slot_idle,      // waiting for req
    slot_pending,   // fields latched, waiting for the frame
    slot_ack        // frame out, waiting for req low
  } slot_state_t;

  typedef enum logic [3:0] {
    snd_idle,
    snd_pre,
    snd_sfd,
    snd_dst,
    snd_src,
    snd_type,
    snd_pay,
    snd_fcs,
    snd_gap
  } send_state_t;

endpackage

`default_nettype wire

/* hdl/tx_channel_slot.sv */
//--------------------------------------------------------------------------
// transmit channel slot
// four-phase req/ack with one source, holds length and destination
// until the frame has been sent
//--------------------------------------------------------------------------

`default_nettype none
`timescale 1ns/1ps

module tx_channel_slot (
  input  wire logic           tx_clock,
  input  wire logic           arst_n,
  input  wire logic           req,       // from source
  input  eth_tx_pkg::len_t    len_in,
  input  eth_tx_pkg::mac_t    dst_in,
  input  wire logic           done,      // frame of this slot finished
  output logic                ack,
  output logic                pending,
  output eth_tx_pkg::len_t    len_out,
  output eth_tx_pkg::mac_t    dst_out
);

  import eth_tx_pkg::*;

  slot_state_t state;
  logic        take;   // accept a new request this cycle

  assign take = (state == slot_idle) && req;

  //------------------------------------------------------------------------
  // handshake fsm
  //------------------------------------------------------------------------
  always_ff @(posedge tx_clock or negedge arst_n) begin
    if (!arst_n) begin
      state <= slot_idle;
    end else begin
      case (state)
        slot_idle: begin
          if (req) state <= slot_pending;
        end
        slot_pending: begin
          if (done) state <= slot_ack;   // held req keeps waiting here
        end
        slot_ack: begin
          if (!req) state <= slot_idle;  // source closed the handshake
        end
        default: state <= slot_idle;
      endcase
    end
  end

  // request fields, frozen from latch until ack
  always_ff @(posedge tx_clock) begin
    if (take) begin
      len_out <= len_in;
      dst_out <= dst_in;
    end
  end

  assign pending = (state == slot_pending);
  assign ack     = (state == slot_ack);

endmodule

`default_nettype wire

/* hdl/tx_arbiter.sv */
//--------------------------------------------------------------------------
// transmit arbiter
// fixed priority over pending slots, arp first and udp last; holds the
// grant for the whole frame and returns completion to the winner
//--------------------------------------------------------------------------

`default_nettype none
`timescale 1ns/1ps

module tx_arbiter (
  input  wire logic                                          tx_clock,
  input  wire logic                                          arst_n,
  input  wire logic [eth_tx_pkg::num_channels-1:0]           pending,
  input  eth_tx_pkg::len_t [eth_tx_pkg::num_channels-1:0]    len_in,
  input  eth_tx_pkg::mac_t [eth_tx_pkg::num_channels-1:0]    dst_in,
  input  wire logic                                          send_ready,
  input  wire logic                                          send_done,
  output logic [eth_tx_pkg::num_channels-1:0]                slot_done,
  output logic                                               start,
  output eth_tx_pkg::chan_t                                  chan,
  output eth_tx_pkg::len_t                                   len,
  output eth_tx_pkg::mac_t                                   dst
);

  import eth_tx_pkg::*;

  logic  busy;     // grant outstanding until send_done
  logic  grant;    // issue a new start this cycle
  chan_t pick;     // highest priority pending channel

  //------------------------------------------------------------------------
  // priority select
  //------------------------------------------------------------------------
  always_comb begin
    if (pending[ch_arp])
      pick = ch_arp;
    else if (pending[ch_icmp])
      pick = ch_icmp;
    else if (pending[ch_dhcp])
      pick = ch_dhcp;
    else
      pick = ch_udp;   // only matters when udp is pending
  end

  assign grant = !busy && send_ready && (|pending);

  //------------------------------------------------------------------------
  // grant register
  //------------------------------------------------------------------------
  always_ff @(posedge tx_clock or negedge arst_n) begin
    if (!arst_n) begin
      busy  <= 1'b0;
      start <= 1'b0;
      chan  <= ch_arp;
    end else begin
      start <= 1'b0;            // single cycle pulse
      if (send_done) begin
        busy <= 1'b0;           // next pick waits for ready
      end else if (grant) begin
        busy  <= 1'b1;
        start <= 1'b1;
        chan  <= pick;
      end
    end
  end

  // muxed request fields, stable for the sender during the frame
  always_ff @(posedge tx_clock) begin
    if (grant) begin
      len <= len_in[pick];
      dst <= dst_in[pick];
    end
  end

  // completion back to the granted slot only
  always_comb begin
    slot_done       = '0;
    slot_done[chan] = send_done && busy;
  end

endmodule

`default_nettype wire

/* hdl/frame_sender.sv */
//--------------------------------------------------------------------------
// frame sender
// one byte per cycle: preamble, sfd, mac header, ethertype, payload
// pulled from the granted source, crc-32 fcs, then the inter-frame gap
//--------------------------------------------------------------------------

`default_nettype none
`timescale 1ns/1ps

module frame_sender (
  input  wire logic         tx_clock,
  input  wire logic         arst_n,
  input  wire logic         start,       // from arbiter, one cycle
  input  eth_tx_pkg::chan_t chan,
  input  eth_tx_pkg::len_t  len,
  input  eth_tx_pkg::mac_t  dst,
  input  eth_tx_pkg::mac_t  local_mac,
  input  eth_tx_pkg::byte_t payload,     // registered at source
  output logic              ready,
  output logic              done,
  output logic              payload_rd,
  output eth_tx_pkg::chan_t payload_ch,
  output eth_tx_pkg::byte_t tx_data,
  output logic              tx_en
);

  import eth_tx_pkg::*;

  send_state_t state;
  len_t        cnt;         // byte index inside the current field
  len_t        cnt_last;    // last index of the current field
  logic        at_last;
  logic [15:0] ether_type;
  crc_t        crc_q;
  crc_t        fcs_word;

  // bytewise update, lsb first as on the wire
  function automatic crc_t crc_step(crc_t crc_in, byte_t data);
    crc_t c;
    c = crc_in ^ {24'd0, data};
    for (int b = 0; b < 8; b++) begin
      c = c[0] ? ((c >> 1) ^ crc_poly) : (c >> 1);
    end
    return c;
  endfunction

  assign ether_type = (chan == ch_arp) ? ethertype_arp : ethertype_ip;
  assign fcs_word   = ~crc_q;   // final inversion

  //------------------------------------------------------------------------
  // field length per state
  //------------------------------------------------------------------------
  always_comb begin
    case (state)
      snd_pre:          cnt_last = len_t'(preamble_len - 1);
      snd_dst, snd_src: cnt_last = len_t'(mac_bytes - 1);
      snd_type:         cnt_last = len_t'(type_bytes - 1);
      snd_pay:          cnt_last = len - 1'b1;
      snd_fcs:          cnt_last = len_t'(fcs_bytes - 1);
      snd_gap:          cnt_last = len_t'(ifg_len - 1);
      default:          cnt_last = '0;   // idle and sfd are one step
    endcase
  end

  assign at_last = (cnt == cnt_last);

  //------------------------------------------------------------------------
  // sequencer
  //------------------------------------------------------------------------
  always_ff @(posedge tx_clock or negedge arst_n) begin
    if (!arst_n) begin
      state <= snd_idle;
      cnt   <= '0;
    end else begin
      cnt <= at_last ? '0 : cnt + 1'b1;
      case (state)
        snd_idle: if (start)   state <= snd_pre;
        snd_pre:  if (at_last) state <= snd_sfd;
        snd_sfd:               state <= snd_dst;
        snd_dst:  if (at_last) state <= snd_src;
        snd_src:  if (at_last) state <= snd_type;
        snd_type: if (at_last) state <= snd_pay;
        snd_pay:  if (at_last) state <= snd_fcs;
        snd_fcs:  if (at_last) state <= snd_gap;
        snd_gap:  if (at_last) state <= snd_idle;   // ready again
        default:               state <= snd_idle;
      endcase
    end
  end

  //------------------------------------------------------------------------
  // byte mux
  //------------------------------------------------------------------------
  always_comb begin
    case (state)
      snd_pre:  tx_data = preamble_byte;
      snd_sfd:  tx_data = sfd_byte;
      snd_dst:  tx_data = dst[47 - 8*cnt[2:0] -: 8];          // msb first
      snd_src:  tx_data = local_mac[47 - 8*cnt[2:0] -: 8];
      snd_type: tx_data = ether_type[15 - 8*cnt[0] -: 8];
      snd_pay:  tx_data = payload;                           // pulled last cycle
      snd_fcs:  tx_data = fcs_word[8*cnt[1:0] +: 8];          // lsb first
      default:  tx_data = '0;
    endcase
  end

  // crc runs over dst, src, type and payload as they go out
  always_ff @(posedge tx_clock) begin
    if (state == snd_idle)
      crc_q <= crc_init;
    else if (state inside {snd_dst, snd_src, snd_type, snd_pay})
      crc_q <= crc_step(crc_q, tx_data);
  end

  assign tx_en = !(state inside {snd_idle, snd_gap});
  assign ready = (state == snd_idle);
  assign done  = (state == snd_fcs) && at_last;   // rides on the last fcs byte

  // len reads, first one a cycle ahead of the first payload byte
  assign payload_rd = ((state == snd_type) && at_last) ||
                      ((state == snd_pay) && !at_last);
  assign payload_ch = chan;

endmodule

`default_nettype wire

/* hdl/eth_tx_top.sv */
//--------------------------------------------------------------------------
// ethernet transmit scheduler, top level
// four request slots, fixed-priority arbiter and byte-wide frame sender
//--------------------------------------------------------------------------

`default_nettype none
`timescale 1ns/1ps

module eth_tx_top (
  input  wire logic                                        tx_clock,
  input  wire logic                                        arst_n,
  input  eth_tx_pkg::mac_t                                 local_mac,
  input  wire logic [eth_tx_pkg::num_channels-1:0]         src_req,
  output logic [eth_tx_pkg::num_channels-1:0]              src_ack,
  input  eth_tx_pkg::len_t [eth_tx_pkg::num_channels-1:0]  src_len,
  input  eth_tx_pkg::mac_t [eth_tx_pkg::num_channels-1:0]  src_dst_mac,
  output logic                                             payload_rd,
  output eth_tx_pkg::chan_t                                payload_ch,
  input  eth_tx_pkg::byte_t                                payload,
  output eth_tx_pkg::byte_t                                tx_data,
  output logic                                             tx_en
);

  import eth_tx_pkg::*;

  // slots to arbiter
  logic [num_channels-1:0] pending;
  logic [num_channels-1:0] slot_done;
  len_t [num_channels-1:0] slot_len;
  mac_t [num_channels-1:0] slot_dst;

  // arbiter to sender
  logic  start;
  chan_t chan;
  len_t  len;
  mac_t  dst;
  logic  send_ready;
  logic  send_done;

  //------------------------------------------------------------------------
  // one slot per source
  //------------------------------------------------------------------------
  for (genvar i = 0; i < num_channels; i++) begin : g_slot
    tx_channel_slot slot_i (
      .tx_clock (tx_clock),
      .arst_n   (arst_n),
      .req      (src_req[i]),
      .len_in   (src_len[i]),
      .dst_in   (src_dst_mac[i]),
      .done     (slot_done[i]),
      .ack      (src_ack[i]),
      .pending  (pending[i]),
      .len_out  (slot_len[i]),
      .dst_out  (slot_dst[i])
    );
  end

  tx_arbiter tx_arbiter_i (
    .tx_clock   (tx_clock),
    .arst_n     (arst_n),
    .pending    (pending),
    .len_in     (slot_len),
    .dst_in     (slot_dst),
    .send_ready (send_ready),
    .send_done  (send_done),
    .slot_done  (slot_done),
    .start      (start),
    .chan       (chan),
    .len        (len),
    .dst        (dst)
  );

  frame_sender frame_sender_i (
    .tx_clock   (tx_clock),
    .arst_n     (arst_n),
    .start      (start),
    .chan       (chan),
    .len        (len),
    .dst        (dst),
    .local_mac  (local_mac),
    .payload    (payload),
    .ready      (send_ready),
    .done       (send_done),
    .payload_rd (payload_rd),
    .payload_ch (payload_ch),
    .tx_data    (tx_data),
    .tx_en      (tx_en)
  );

endmodule

`default_nettype wire

/* dv/eth_tx_props.sv */
//--------------------------------------------------------------------------
// transmit scheduler assertions
// source handshakes, payload reads and the inter-frame gap
//--------------------------------------------------------------------------

`default_nettype none
`timescale 1ns/1ps

module eth_tx_props (
  input wire logic                                  tx_clock,
  input wire logic                                  arst_n,
  input wire logic [eth_tx_pkg::num_channels-1:0]   src_req,
  input wire logic [eth_tx_pkg::num_channels-1:0]   src_ack,
  input wire logic                                  payload_rd,
  input wire logic                                  tx_en
);

  import eth_tx_pkg::*;

  logic [7:0] idle_run;   // low tx_en cycles since the last frame, saturating

  always_ff @(posedge tx_clock or negedge arst_n) begin
    if (!arst_n)
      idle_run <= 8'hff;
    else if (tx_en)
      idle_run <= '0;
    else if (idle_run != 8'hff)
      idle_run <= idle_run + 1'b1;
  end

  //------------------------------------------------------------------------
  // per channel handshake
  //------------------------------------------------------------------------
  for (genvar i = 0; i < num_channels; i++) begin : g_chan
    ack_needs_req: assert property (@(posedge tx_clock) disable iff (!arst_n)
      $rose(src_ack[i]) |-> src_req[i])
      else $error("ack rose without req on channel %0d", i);

    req_until_ack: assert property (@(posedge tx_clock) disable iff (!arst_n)
      src_req[i] && !src_ack[i] |=> src_req[i])
      else $error("req dropped before ack on channel %0d", i);
  end

  // reads only inside a frame, next byte goes out
  rd_in_frame: assert property (@(posedge tx_clock) disable iff (!arst_n)
    payload_rd |-> tx_en ##1 tx_en)
    else $error("payload read outside a frame");

  gap_kept: assert property (@(posedge tx_clock) disable iff (!arst_n)
    $rose(tx_en) |-> idle_run >= ifg_len)
    else $error("inter-frame gap shorter than %0d cycles", ifg_len);

endmodule

`default_nettype wire

/* dv/tb_eth_tx.sv */
//--------------------------------------------------------------------------
// testbench for the ethernet transmit scheduler
// four random sources, frame model with crc-32, byte monitor on tx_data
//--------------------------------------------------------------------------

`default_nettype none
`timescale 1ns/1ps

module tb_eth_tx;

  import eth_tx_pkg::*;

  localparam int seed           = 47432;
  localparam int max_len        = 64;
  localparam int max_idle       = 30;    // idle cycles between requests
  localparam int rand_reqs      = 50;    // per channel, 200 in all
  localparam int timeout_factor = 4;
  localparam int frame_ovh      = 26;    // 7+1+6+6+2 header, 4 fcs
  localparam int num_frames     = 2*num_channels + num_channels*rand_reqs;
  localparam int wd_cycles      = timeout_factor *
    (num_frames*(frame_ovh + max_len + ifg_len + 8) + rand_reqs*max_idle);

  logic                    tx_clock;
  logic                    arst_n;
  mac_t                    local_mac;
  logic [num_channels-1:0] src_req;
  logic [num_channels-1:0] src_ack;
  len_t [num_channels-1:0] src_len;
  mac_t [num_channels-1:0] src_dst_mac;
  logic                    payload_rd;
  chan_t                   payload_ch;
  byte_t                   payload;
  byte_t                   tx_data;
  logic                    tx_en;

  //------------------------------------------------------------------------
  // model state, at most one open request per channel
  //------------------------------------------------------------------------
  byte_t exp_bytes [num_channels][$];   // whole expected frame
  byte_t pay_q     [num_channels][$];   // bytes still to hand out
  len_t  exp_len   [num_channels];
  crc_t  exp_crc   [num_channels];      // fcs word as sent
  logic  exp_open  [num_channels];
  int    sent_cnt  [num_channels];
  int    req_cnt   [num_channels];
  chan_t seen_order[$];

  byte_t rx_q[$];                       // monitor, current frame
  logic  in_frame     = 1'b0;
  logic  ch_seen      = 1'b0;
  chan_t frame_ch     = '0;
  int    gap_run      = 100;            // low cycles since last frame
  int    mismatch_cnt = 0;
  int    error_cnt    = 0;
  int    frame_cnt    = 0;
  string test_name    = "reset";

  eth_tx_top eth_tx_top_i (
    .tx_clock    (tx_clock),
    .arst_n      (arst_n),
    .local_mac   (local_mac),
    .src_req     (src_req),
    .src_ack     (src_ack),
    .src_len     (src_len),
    .src_dst_mac (src_dst_mac),
    .payload_rd  (payload_rd),
    .payload_ch  (payload_ch),
    .payload     (payload),
    .tx_data     (tx_data),
    .tx_en       (tx_en)
  );

  bind eth_tx_top eth_tx_props eth_tx_props_i (
    .tx_clock   (tx_clock),
    .arst_n     (arst_n),
    .src_req    (src_req),
    .src_ack    (src_ack),
    .payload_rd (payload_rd),
    .tx_en      (tx_en)
  );

  initial begin
    tx_clock = 1'b0;
    forever #20 tx_clock = ~tx_clock;   // 40 ns period
  end

  // reference crc, one bit per step, lsb of each byte first
  function automatic crc_t model_crc(crc_t c, byte_t d);
    crc_t r;
    logic fb;
    r = c;
    for (int k = 0; k < 8; k++) begin
      fb = r[0] ^ d[k];
      r  = r >> 1;
      if (fb) r = r ^ crc_poly;
    end
    return r;
  endfunction

  //------------------------------------------------------------------------
  // compare tasks
  //------------------------------------------------------------------------
  task automatic cmp_byte(input string name, input byte_t exp, input byte_t act);
    if (exp !== act) begin
      mismatch_cnt++;
      $display("MISMATCH %s: expected %02h, actual %02h", name, exp, act);
    end
  endtask

  task automatic cmp_chan(input string name, input chan_t exp, input chan_t act);
    if (exp !== act) begin
      mismatch_cnt++;
      $display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic cmp_crc(input string name, input crc_t exp, input crc_t act);
    if (exp !== act) begin
      mismatch_cnt++;
      $display("MISMATCH %s: expected %08h, actual %08h", name, exp, act);
    end
  endtask

  task automatic cmp_len(input string name, input len_t exp, input len_t act);
    if (exp !== act) begin
      mismatch_cnt++;
      $display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic report_counts();
    $display("errors: %0d mismatches, %0d other failures, %0d frames seen",
             mismatch_cnt, error_cnt, frame_cnt);
  endtask

  //------------------------------------------------------------------------
  // frame model
  //------------------------------------------------------------------------
  task automatic build_frame(input int ch, input len_t len, input mac_t dst);
    crc_t        c;
    byte_t       b;
    logic [15:0] etype;
    etype = (ch == ch_arp) ? ethertype_arp : ethertype_ip;
    exp_bytes[ch].delete();
    repeat (preamble_len) exp_bytes[ch].push_back(preamble_byte);
    exp_bytes[ch].push_back(sfd_byte);
    for (int i = 5; i >= 0; i--) exp_bytes[ch].push_back(dst[8*i +: 8]);  // msb first
    for (int i = 5; i >= 0; i--) exp_bytes[ch].push_back(local_mac[8*i +: 8]);
    exp_bytes[ch].push_back(etype[15:8]);
    exp_bytes[ch].push_back(etype[7:0]);
    for (int i = 0; i < len; i++) begin
      b = 8'($urandom());
      pay_q[ch].push_back(b);
      exp_bytes[ch].push_back(b);
    end
    c = crc_init;
    for (int i = 8; i < exp_bytes[ch].size(); i++) c = model_crc(c, exp_bytes[ch][i]);
    c = ~c;
    for (int i = 0; i < 4; i++) exp_bytes[ch].push_back(c[8*i +: 8]);   // lsb first
    exp_crc[ch]  = c;
    exp_len[ch]  = len;
    exp_open[ch] = 1'b1;
  endtask

  // one full four-phase handshake on channel ch
  task automatic run_request(input int ch);
    len_t l;
    mac_t d;
    int   wait_n;
    l        = len_t'($urandom_range(max_len, 1));
    d[47:32] = 16'($urandom());
    d[31:0]  = $urandom();
    build_frame(ch, l, d);
    req_cnt[ch]++;
    @(posedge tx_clock);
    src_len[ch]     <= l;
    src_dst_mac[ch] <= d;
    src_req[ch]     <= 1'b1;
    do @(negedge tx_clock); while (!src_ack[ch]);   // watchdog bounds this
    @(posedge tx_clock);   // monitor has closed the frame by now
    if (exp_open[ch] || sent_cnt[ch] != req_cnt[ch]) begin
      error_cnt++;
      $display("ERROR %s: ack on channel %0d came before its frame ended", test_name, ch);
    end
    src_req[ch] <= 1'b0;
    wait_n = 0;
    do begin
      @(negedge tx_clock);
      wait_n++;
    end while (src_ack[ch] && wait_n < 4);
    if (src_ack[ch]) begin
      error_cnt++;
      $display("ERROR %s: ack on channel %0d stayed high after req fell", test_name, ch);
    end
  endtask

  task automatic run_source(input int ch);
    repeat (rand_reqs) begin
      repeat ($urandom_range(max_idle, 0)) @(posedge tx_clock);
      run_request(ch);
    end
  endtask

  task automatic check_order();
    if (seen_order.size() != num_channels) begin
      error_cnt++;
      $display("ERROR %s: %0d frames seen instead of %0d", test_name, seen_order.size(),
               num_channels);
    end else begin
      for (int i = 0; i < num_channels; i++)
        cmp_chan($sformatf("%s order %0d", test_name, i), chan_t'(i), seen_order[i]);
    end
  endtask

  //------------------------------------------------------------------------
  // monitor, sampled on the falling edge
  //------------------------------------------------------------------------
  task automatic check_frame();
    int   n;
    crc_t fcs;
    n = rx_q.size();
    frame_cnt++;
    if (!ch_seen || n < frame_ovh) begin
      error_cnt++;
      $display("ERROR %s: frame of %0d bytes without a payload pull", test_name, n);
      return;
    end
    if (!exp_open[frame_ch]) begin
      error_cnt++;
      $display("ERROR %s: frame on channel %0d with no open request", test_name, frame_ch);
      return;
    end
    cmp_len({test_name, " payload length"}, exp_len[frame_ch], len_t'(n - frame_ovh));
    for (int i = 0; i < n && i < exp_bytes[frame_ch].size(); i++)
      cmp_byte($sformatf("%s ch%0d byte %0d", test_name, frame_ch, i),
               exp_bytes[frame_ch][i], rx_q[i]);
    fcs = {rx_q[n-1], rx_q[n-2], rx_q[n-3], rx_q[n-4]};
    cmp_crc({test_name, " fcs"}, exp_crc[frame_ch], fcs);
    exp_open[frame_ch] = 1'b0;
    sent_cnt[frame_ch]++;
    seen_order.push_back(frame_ch);
  endtask

  initial begin
    forever begin
      @(negedge tx_clock);
      if (arst_n && tx_en) begin
        if (!in_frame) begin
          if (gap_run < ifg_len) begin
            error_cnt++;
            $display("ERROR %s: only %0d idle cycles before a frame", test_name, gap_run);
          end
          rx_q.delete();
          ch_seen = 1'b0;
        end
        in_frame = 1'b1;
        rx_q.push_back(tx_data);
        if (payload_rd && !ch_seen) begin
          frame_ch = payload_ch;   // channel of this frame
          ch_seen  = 1'b1;
        end else if (payload_rd) begin
          cmp_chan({test_name, " payload_ch"}, frame_ch, payload_ch);
        end
      end else if (arst_n) begin
        if (in_frame) begin
          check_frame();
          gap_run = 0;
        end
        in_frame = 1'b0;
        gap_run++;
      end
    end
  end

  // registered payload source, one byte per read
  initial begin
    logic  rd;
    chan_t rd_ch;
    payload <= '0;
    forever begin
      @(negedge tx_clock);
      rd    = payload_rd;   // read request of this cycle
      rd_ch = payload_ch;
      @(posedge tx_clock);
      if (rd && pay_q[rd_ch].size() == 0) begin
        error_cnt++;
        $display("ERROR %s: payload read on channel %0d with no bytes left", test_name,
                 rd_ch);
      end else if (rd) begin
        payload <= pay_q[rd_ch].pop_front();
      end
    end
  end

  //------------------------------------------------------------------------
  // stimulus
  //------------------------------------------------------------------------
  initial begin
    void'($urandom(seed));
    arst_n      <= 1'b0;
    local_mac   <= 48'h02005ea1b2c3;
    src_req     <= '0;
    src_len     <= '0;
    src_dst_mac <= '0;
    for (int c = 0; c < num_channels; c++) begin
      exp_open[c] = 1'b0;
      sent_cnt[c] = 0;
      req_cnt[c]  = 0;
    end
    repeat (5) @(posedge tx_clock);
    arst_n <= 1'b1;
    repeat (2) @(posedge tx_clock);

    test_name = "single";   // each channel in turn
    for (int c = 0; c < num_channels; c++) run_request(c);
    check_order();

    test_name = "burst";    // all four in one cycle
    seen_order.delete();
    fork
      run_request(0);
      run_request(1);
      run_request(2);
      run_request(3);
    join
    check_order();

    test_name = "random";
    fork
      run_source(0);
      run_source(1);
      run_source(2);
      run_source(3);
    join

    repeat (ifg_len + 4) @(posedge tx_clock);
    for (int c = 0; c < num_channels; c++) begin
      if (exp_open[c] || pay_q[c].size() != 0 || sent_cnt[c] != req_cnt[c]) begin
        error_cnt++;
        $display("ERROR: channel %0d lost a request, %0d sent of %0d", c, sent_cnt[c],
                 req_cnt[c]);
      end
    end
    report_counts();
    if (mismatch_cnt == 0 && error_cnt == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

  // watchdog
  initial begin
    repeat (wd_cycles) @(posedge tx_clock);
    $display("ERROR: the run timed out after %0d cycles in test %s", wd_cycles, test_name);
    report_counts();
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
hdl/eth_tx_pkg.sv
hdl/tx_channel_slot.sv
hdl/tx_arbiter.sv
hdl/frame_sender.sv
hdl/eth_tx_top.sv
dv/eth_tx_props.sv
dv/tb_eth_tx.sv

/* Makefile */
# Verilator build and run for the ethernet transmit scheduler testbench

VERILATOR ?= verilator
TOP       ?= tb_eth_tx
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All tests passed

SRCS := $(shell cat $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the testbench printed the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
